// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_accel
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

SRCS := $(shell grep -v '^+' $(FILELIST)) testbench/tb_ref_model.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+testbench
logic/cnn_num_pkg.sv
logic/csb_cmd_pkg.sv
logic/cmd_fifo.sv
logic/csb.sv
logic/cmac.sv
logic/maxpool_3x3.sv
logic/avepool_13x13.sv
logic/engine.sv
logic/accel_top.sv
testbench/tb_accel.sv

// ==== logic/accel_top.sv ====
// No back-pressure on results; out_valid is a single-cycle pulse that must be taken at once
`timescale 1ns/100ps

module accel_top (
	input  logic                   okClk,
	input  logic                   rst,
	input  logic                   cmd_wr,
	input  csb_cmd_pkg::cmd_word_u cmd,
	output logic                   cmd_full,
	input  logic                   in_valid,
	input  csb_cmd_pkg::operand_t  in_op,
	output logic                   in_ready,
	output logic                   out_valid,
	output csb_cmd_pkg::result_t   out_res,
	output logic                   cmd_err
);
	import cnn_num_pkg::*;
	import csb_cmd_pkg::*;

	cmd_word_u  head_cmd;
	logic       head_empty;
	logic       pop;
	logic       op_valid;
	logic       conv_ready;
	logic       maxpool_ready;
	logic       avepool_ready;
	logic [7:0] conv_taps;
	fix16_t     conv_bias;
	logic       conv_valid;
	logic       maxpool_valid;
	logic       avepool_valid;

	cmd_fifo u_cmd_fifo (
		.okClk (okClk),
		.rst   (rst),
		.wr    (cmd_wr),
		.wdata (cmd),
		.pop   (pop),
		.rdata (head_cmd),
		.empty (head_empty),
		.full  (cmd_full)
	);

	csb u_csb (
		.okClk         (okClk),
		.rst           (rst),
		.fifo_empty    (head_empty),
		.fifo_cmd      (head_cmd),
		.pop           (pop),
		.in_valid      (in_valid),
		.op_valid      (op_valid),
		.conv_ready    (conv_ready),
		.maxpool_ready (maxpool_ready),
		.avepool_ready (avepool_ready),
		.conv_taps     (conv_taps),
		.conv_bias     (conv_bias),
		.conv_valid    (conv_valid),
		.maxpool_valid (maxpool_valid),
		.avepool_valid (avepool_valid),
		.in_ready      (in_ready),
		.cmd_err       (cmd_err)
	);

	engine u_engine (
		.okClk         (okClk),
		.rst           (rst),
		.conv_ready    (conv_ready),
		.maxpool_ready (maxpool_ready),
		.avepool_ready (avepool_ready),
		.op_valid      (op_valid),
		.op            (in_op),
		.conv_taps     (conv_taps),
		.conv_bias     (conv_bias),
		.conv_valid    (conv_valid),
		.maxpool_valid (maxpool_valid),
		.avepool_valid (avepool_valid),
		.res_valid     (out_valid),
		.res           (out_res)
	);

endmodule

// ==== logic/avepool_13x13.sv ====
// Mean is sum * 388 >>> 16, truncated toward minus infinity and clipped to Q8.8
`timescale 1ns/100ps

module avepool_13x13 (
	input  logic                okClk,
	input  logic                rst,
	input  logic                pool_ready,
	input  logic                op_valid,
	input  cnn_num_pkg::fix16_t data,
	output cnn_num_pkg::fix16_t om,
	output logic                pool_valid
);
	import cnn_num_pkg::*;

	logic [7:0] cnt;               // 0 to 168
	acc_t       sum_q;
	acc_t       sum_next;
	acc_t       mul_in;
	acc_t       prod;
	logic       beat;
	logic       win_end;
	logic       mul_v;

	assign beat    = pool_ready && op_valid;
	assign win_end = (cnt == 8'(AVEPOOL_WIN - 1));

	//------------------------------
	// Sum stage
	//------------------------------
	assign sum_next = ((cnt == 8'd0) ? acc_t'(0) : sum_q) + acc_t'(data);

	always_ff @(posedge okClk) begin
		if (rst) begin
			cnt        <= '0;
			mul_v      <= 1'b0;
			pool_valid <= 1'b0;
		end else begin
			mul_v      <= beat && win_end;
			pool_valid <= mul_v;
			if (!pool_ready)
				cnt <= '0;
			else if (beat)
				cnt <= win_end ? 8'd0 : cnt + 8'd1;
		end
	end

	always_ff @(posedge okClk) begin
		if (beat)
			sum_q <= sum_next;
		if (beat && win_end)
			mul_in <= sum_next;    // Frees the sum for the next window
	end

	//------------------------------
	// Reciprocal multiply stage
	//------------------------------
	assign prod = mul_in * acc_t'(AVE_RECIP);

	always_ff @(posedge okClk) begin
		if (mul_v)
			om <= sat16(prod >>> 16);  // Back from Q0.16
	end

endmodule

// ==== logic/cmac.sv ====
// Accumulator is cleared only by start; result is (sum >>> 8) + bias, clipped to Q8.8
`timescale 1ns/100ps

module cmac (
	input  logic                okClk,
	input  logic                rst,
	input  logic                start,
	input  logic                op_valid,
	input  cnn_num_pkg::fix16_t data,
	input  cnn_num_pkg::fix16_t weight,
	input  logic                last,
	input  cnn_num_pkg::fix16_t bias,
	output cnn_num_pkg::fix16_t result,
	output logic                conv_valid
);
	import cnn_num_pkg::*;

	logic signed [31:0] prod_q;    // Q16.16
	logic               p_valid;
	logic               p_last;
	acc_t               acc_q;
	acc_t               acc_next;

	//------------------------------
	// Stage 1, product
	//------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			p_valid <= 1'b0;
			p_last  <= 1'b0;
		end else begin
			p_valid <= op_valid;
			p_last  <= op_valid && last;
		end
	end

	always_ff @(posedge okClk) begin
		if (op_valid)
			prod_q <= data * weight;
	end

	//------------------------------
	// Stage 2, accumulate
	//------------------------------
	assign acc_next = acc_q + acc_t'(prod_q);

	always_ff @(posedge okClk) begin
		if (start)
			acc_q <= '0;               // First beat lands here one cycle later
		else if (p_valid)
			acc_q <= acc_next;
	end

	always_ff @(posedge okClk) begin
		if (p_last)
			result <= sat16((acc_next >>> FRAC_BITS) + acc_t'(bias));
	end

	always_ff @(posedge okClk) begin
		if (rst)
			conv_valid <= 1'b0;
		else
			conv_valid <= p_last;
	end

endmodule

// ==== logic/cmd_fifo.sv ====
// Writes while full are dropped, a pop on an empty queue is ignored, and rdata is the head
`timescale 1ns/100ps

module cmd_fifo (
	input  logic                   okClk,
	input  logic                   rst,
	input  logic                   wr,
	input  csb_cmd_pkg::cmd_word_u wdata,
	input  logic                   pop,
	output csb_cmd_pkg::cmd_word_u rdata,
	output logic                   empty,
	output logic                   full
);
	import csb_cmd_pkg::*;

	cmd_word_u         mem [CMD_DEPTH];
	logic [CMD_AW-1:0] wr_ptr;
	logic [CMD_AW-1:0] rd_ptr;
	logic [CMD_AW:0]   count;
	logic              do_wr;
	logic              do_rd;

	assign do_wr = wr && !full;
	assign do_rd = pop && !empty;
	assign empty = (count == '0);
	assign full  = (count == (CMD_AW+1)'(CMD_DEPTH));
	assign rdata = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	// Pointers wrap naturally
	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// A refused write leaves the queue full with both pointers on the same slot
	a_full_write: assert property (@(posedge okClk) disable iff (rst)
		(wr && full && !pop) |=> (full && (wr_ptr == rd_ptr)))
		else $error("cmd_fifo: write while full reached the queue");

endmodule

// ==== logic/cnn_num_pkg.sv ====
// Signed Q8.8 data only; sat16 clips to the 16-bit range and never rounds
package cnn_num_pkg;

	//------------------------------
	// Sample and accumulator types
	//------------------------------
	typedef logic signed [15:0] fix16_t;   // Q8.8
	typedef logic signed [39:0] acc_t;     // Wide enough for 255 full-scale taps

	localparam int PARA      = 4;          // Convolution lanes sharing one data stream
	localparam int FRAC_BITS = 8;

	localparam fix16_t FIX_MAX = 16'sh7FFF;
	localparam fix16_t FIX_MIN = 16'sh8000;

	// One value per lane, lane 0 in the low bits
	typedef fix16_t [PARA-1:0] lane_vec_t;

	//------------------------------
	// Pool windows
	//------------------------------
	localparam int MAXPOOL_WIN = 9;
	localparam int AVEPOOL_WIN = 169;
	localparam logic [16:0] AVE_RECIP = 17'd388;  // 1/169 in Q0.16

	// Clip a wide signed value into fix16_t
	function automatic fix16_t sat16(input acc_t v);
		if (v > acc_t'(FIX_MAX))
			return FIX_MAX;
		else if (v < acc_t'(FIX_MIN))
			return FIX_MIN;
		return fix16_t'(v);
	endfunction

endpackage

// ==== logic/csb.sv ====
// One command at a time; the operand source must hold in_valid low while in_ready is low
`timescale 1ns/100ps

module csb (
	input  logic                   okClk,
	input  logic                   rst,
	input  logic                   fifo_empty,
	input  csb_cmd_pkg::cmd_word_u fifo_cmd,
	output logic                   pop,
	input  logic                   in_valid,
	output logic                   op_valid,
	output logic                   conv_ready,
	output logic                   maxpool_ready,
	output logic                   avepool_ready,
	output logic [7:0]             conv_taps,
	output cnn_num_pkg::fix16_t    conv_bias,
	input  logic                   conv_valid,
	input  logic                   maxpool_valid,
	input  logic                   avepool_valid,
	output logic                   in_ready,
	output logic                   cmd_err
);
	import cnn_num_pkg::*;
	import csb_cmd_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN, S_DRAIN} state_e;

	state_e      state;
	opcode_e     op_q;
	logic [15:0] op_cnt;
	logic [15:0] op_total;
	logic [15:0] load_total;
	logic [7:0]  res_cnt;
	logic [7:0]  res_total;
	logic [7:0]  load_res;
	logic        res_pulse;
	logic        last_op;

	//------------------------------
	// Decode of the head command
	//------------------------------
	always_comb begin
		case (fifo_cmd.conv.opcode)
			OP_CONV: begin
				load_total = {8'd0, fifo_cmd.conv.taps};
				load_res   = 8'd1;                     // All lanes report together
			end
			OP_MAXPOOL: begin
				load_total = 16'(fifo_cmd.pool.windows * MAXPOOL_WIN);
				load_res   = fifo_cmd.pool.windows;
			end
			OP_AVEPOOL: begin
				load_total = 16'(fifo_cmd.pool.windows * AVEPOOL_WIN);
				load_res   = fifo_cmd.pool.windows;
			end
			default: begin
				load_total = '0;
				load_res   = '0;
			end
		endcase
	end

	assign pop     = (state == S_LOAD);
	assign cmd_err = pop && (fifo_cmd.conv.opcode == OP_RSVD);

	assign conv_ready    = (state == S_RUN) && (op_q == OP_CONV);
	assign maxpool_ready = (state == S_RUN) && (op_q == OP_MAXPOOL);
	assign avepool_ready = (state == S_RUN) && (op_q == OP_AVEPOOL);
	assign in_ready      = conv_ready | maxpool_ready | avepool_ready;

	assign op_valid  = in_valid && in_ready;
	assign res_pulse = conv_valid | maxpool_valid | avepool_valid;
	assign last_op   = op_valid && (op_cnt == op_total - 16'd1);

	//------------------------------
	// Sequencer FSM
	//------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			state   <= S_IDLE;
			op_q    <= OP_CONV;
			op_cnt  <= '0;
			res_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (!fifo_empty) state <= S_LOAD;
				S_LOAD: begin
					op_q    <= fifo_cmd.conv.opcode;
					op_cnt  <= '0;
					res_cnt <= '0;
					state   <= (fifo_cmd.conv.opcode == OP_RSVD) ? S_IDLE : S_RUN;
				end
				S_RUN: begin
					if (op_valid)
						op_cnt <= op_cnt + 16'd1;
					if (res_pulse)
						res_cnt <= res_cnt + 8'd1;     // Max-pool windows finish mid-stream
					if (last_op)
						state <= S_DRAIN;
				end
				S_DRAIN: begin
					if (res_pulse)
						res_cnt <= res_cnt + 8'd1;
					if (res_cnt + {7'd0, res_pulse} == res_total)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Command fields held for the engine
	always_ff @(posedge okClk) begin
		if (state == S_LOAD) begin
			conv_taps <= fifo_cmd.conv.taps;
			conv_bias <= fifo_cmd.conv.bias;
			op_total  <= load_total;
			res_total <= load_res;
		end
	end

	a_ready_onehot: assert property (@(posedge okClk) disable iff (rst)
		$onehot0({conv_ready, maxpool_ready, avepool_ready}))
		else $error("csb: more than one core enabled");

	a_no_early_data: assert property (@(posedge okClk) disable iff (rst)
		in_valid |-> in_ready)
		else $error("csb: operand presented while in_ready low");

endmodule

// ==== logic/csb_cmd_pkg.sv ====
// Command word is 32 bits with the opcode in bits 31:30 for every view; counts of 0 are illegal
package csb_cmd_pkg;

	//------------------------------
	// Opcodes
	//------------------------------
	typedef enum logic [1:0] {
		OP_CONV    = 2'd0,
		OP_MAXPOOL = 2'd1,
		OP_AVEPOOL = 2'd2,
		OP_RSVD    = 2'd3
	} opcode_e;

	// Convolution view of the command word
	typedef struct packed {
		opcode_e             opcode;
		logic [7:0]          taps;    // Beats per result, 1 to 255
		cnn_num_pkg::fix16_t bias;
		logic [5:0]          spare;
	} conv_cmd_t;

	// Pool view, same opcode position
	typedef struct packed {
		opcode_e     opcode;
		logic [7:0]  windows;         // Windows per command, 1 to 255
		logic [21:0] spare;
	} pool_cmd_t;

	typedef union packed {
		conv_cmd_t conv;
		pool_cmd_t pool;
	} cmd_word_u;

	localparam int CMD_DEPTH = 8;                  // Power of two
	localparam int CMD_AW    = $clog2(CMD_DEPTH);

	//------------------------------
	// Operand and result beats
	//------------------------------
	typedef struct packed {
		cnn_num_pkg::fix16_t    sample;
		cnn_num_pkg::lane_vec_t weights;  // Ignored by the pool cores
	} operand_t;

	typedef struct packed {
		opcode_e                kind;
		cnn_num_pkg::lane_vec_t value;    // Pool results in lane 0 only
	} result_t;

endpackage

// ==== logic/engine.sv ====
// Results leave unregistered from the cores; at most one core reports in any cycle
`timescale 1ns/100ps

module engine (
	input  logic                  okClk,
	input  logic                  rst,
	input  logic                  conv_ready,
	input  logic                  maxpool_ready,
	input  logic                  avepool_ready,
	input  logic                  op_valid,
	input  csb_cmd_pkg::operand_t op,
	input  logic [7:0]            conv_taps,
	input  cnn_num_pkg::fix16_t   conv_bias,
	output logic                  conv_valid,
	output logic                  maxpool_valid,
	output logic                  avepool_valid,
	output logic                  res_valid,
	output csb_cmd_pkg::result_t  res
);
	import cnn_num_pkg::*;
	import csb_cmd_pkg::*;

	logic            conv_ready_q;
	logic            start;
	logic            conv_beat;
	logic            last;
	logic [7:0]      tap_cnt;
	logic [7:0]      tap_cur;
	logic [PARA-1:0] lane_valid;
	lane_vec_t       lane_res;
	fix16_t          max_om;
	fix16_t          ave_om;

	//------------------------------
	// Tap tracking
	//------------------------------
	assign start     = conv_ready && !conv_ready_q;
	assign conv_beat = conv_ready && op_valid;
	assign tap_cur   = start ? 8'd0 : tap_cnt;     // First beat may share the start cycle
	assign last      = conv_beat && (tap_cur == conv_taps - 8'd1);

	always_ff @(posedge okClk) begin
		if (rst) begin
			conv_ready_q <= 1'b0;
			tap_cnt      <= '0;
		end else begin
			conv_ready_q <= conv_ready;
			tap_cnt      <= tap_cur + {7'd0, conv_beat};
		end
	end

	// Shared data, one weight per lane
	for (genvar i = 0; i < PARA; i++) begin : g_lane
		cmac u_cmac (
			.okClk      (okClk),
			.rst        (rst),
			.start      (start),
			.op_valid   (conv_beat),
			.data       (op.sample),
			.weight     (op.weights[i]),
			.last       (last),
			.bias       (conv_bias),
			.result     (lane_res[i]),
			.conv_valid (lane_valid[i])
		);
	end

	assign conv_valid = &lane_valid;

	maxpool_3x3 u_maxpool (
		.okClk      (okClk),
		.rst        (rst),
		.pool_ready (maxpool_ready),
		.op_valid   (op_valid),
		.data       (op.sample),
		.om         (max_om),
		.pool_valid (maxpool_valid)
	);

	avepool_13x13 u_avepool (
		.okClk      (okClk),
		.rst        (rst),
		.pool_ready (avepool_ready),
		.op_valid   (op_valid),
		.data       (op.sample),
		.om         (ave_om),
		.pool_valid (avepool_valid)
	);

	//------------------------------
	// Result merge
	//------------------------------
	assign res_valid = conv_valid | maxpool_valid | avepool_valid;

	always_comb begin
		res = '0;
		if (conv_valid) begin
			res.kind  = OP_CONV;
			res.value = lane_res;
		end else if (maxpool_valid) begin
			res.kind     = OP_MAXPOOL;
			res.value[0] = max_om;
		end else if (avepool_valid) begin
			res.kind     = OP_AVEPOOL;
			res.value[0] = ave_om;
		end
	end

	a_one_result: assert property (@(posedge okClk) disable iff (rst)
		$onehot0({conv_valid, maxpool_valid, avepool_valid}))
		else $error("engine: two cores reported in one cycle");

endmodule

// ==== logic/maxpool_3x3.sv ====
// Window position restarts whenever pool_ready is low; beats arrive in any order within a window
`timescale 1ns/100ps

module maxpool_3x3 (
	input  logic                okClk,
	input  logic                rst,
	input  logic                pool_ready,
	input  logic                op_valid,
	input  cnn_num_pkg::fix16_t data,
	output cnn_num_pkg::fix16_t om,
	output logic                pool_valid
);
	import cnn_num_pkg::*;

	logic [3:0] cnt;               // 0 to 8
	fix16_t     max_q;
	fix16_t     cur_max;
	logic       beat;
	logic       win_end;

	assign beat    = pool_ready && op_valid;
	assign win_end = (cnt == 4'(MAXPOOL_WIN - 1));

	// First beat of a window always wins
	assign cur_max = (cnt == 4'd0 || data > max_q) ? data : max_q;

	always_ff @(posedge okClk) begin
		if (rst) begin
			cnt        <= '0;
			pool_valid <= 1'b0;
		end else begin
			pool_valid <= beat && win_end;
			if (!pool_ready)
				cnt <= '0;
			else if (beat)
				cnt <= win_end ? 4'd0 : cnt + 4'd1;
		end
	end

	always_ff @(posedge okClk) begin
		if (beat)
			max_q <= cur_max;
		if (beat && win_end)
			om <= cur_max;
	end

endmodule

// ==== testbench/tb_ref_model.svh ====
// Expected Q8.8 results with floor shifts and 16-bit clipping; include after cnn_num_pkg is imported
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Clip to the signed 16-bit range
function automatic fix16_t clip_q88(input longint v);
	if (v > 32767)
		return 16'sh7FFF;
	if (v < -32768)
		return 16'sh8000;
	return fix16_t'(v);
endfunction

// Sum of Q16.16 products, back to Q8.8, plus bias
function automatic fix16_t ref_conv(input fix16_t smp[$], input lane_vec_t wts[$],
		input int lane, input fix16_t bias);
	longint sum;
	sum = 0;
	foreach (smp[i])
		sum += longint'(smp[i]) * longint'(wts[i][lane]);
	return clip_q88((sum >>> FRAC_BITS) + longint'(bias));
endfunction

// Signed maximum of one 9-beat window
function automatic fix16_t ref_maxpool(input fix16_t smp[$], input int first);
	fix16_t best;
	int     i;
	best = smp[first];
	for (i = 1; i < MAXPOOL_WIN; i++) begin
		if (smp[first+i] > best)
			best = smp[first+i];
	end
	return best;
endfunction

// Window sum times round(65536 / 169), then back from Q0.16
function automatic fix16_t ref_avepool(input fix16_t smp[$], input int first);
	longint sum;
	longint recip;
	int     i;
	recip = ((longint'(1) << 16) + AVEPOOL_WIN/2) / AVEPOOL_WIN;
	sum   = 0;
	for (i = 0; i < AVEPOOL_WIN; i++)
		sum += longint'(smp[first+i]);
	return clip_q88((sum * recip) >>> 16);
endfunction

`endif

// ==== testbench/tb_accel.sv ====
// Results must come back in command order; operands are offered only while in_ready is high
`timescale 1ns/100ps

module tb_accel;
	import cnn_num_pkg::*;
	import csb_cmd_pkg::*;

	localparam int          CLK_PERIOD = 100;
	localparam int          DRIVE_DLY  = 10;
	localparam logic [31:0] SEED       = 32'h4776_eb52;
	localparam int          CONV_LIM   = 1024;    // Samples within +-4.0
	localparam int          WT_LIM     = 256;     // Weights within +-1.0
	localparam int          BIAS_LIM   = 2048;
	localparam int          POOL_LIM   = 32767;

	// Upper bound of operand beats over all tests
	localparam int OP_BUDGET = 4*32 + 4 + 6*MAXPOOL_WIN + 2*AVEPOOL_WIN
		+ (CMD_DEPTH+2)*2*MAXPOOL_WIN + 5;
	localparam int WATCHDOG_CYCLES = OP_BUDGET*2 + 2000;

	logic      okClk = 1'b0;
	logic      rst;
	logic      cmd_wr;
	cmd_word_u cmd;
	logic      cmd_full;
	logic      in_valid;
	operand_t  in_op;
	logic      in_ready;
	logic      out_valid;
	result_t   out_res;
	logic      cmd_err;

	result_t exp_q[$];
	string   name_q[$];
	result_t got_exp;
	string   got_name;
	int      errors = 0;
	int      checked = 0;
	int      err_pulses = 0;
	int      err_pulses_exp = 0;

	`include "tb_ref_model.svh"

	accel_top DUT (
		.okClk     (okClk),
		.rst       (rst),
		.cmd_wr    (cmd_wr),
		.cmd       (cmd),
		.cmd_full  (cmd_full),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_res   (out_res),
		.cmd_err   (cmd_err)
	);

	always #(CLK_PERIOD/2) okClk = ~okClk;

	//------------------------------
	// Helpers
	//------------------------------
	function automatic fix16_t rand_fix(input int lim);
		int unsigned r;
		r = $urandom % (2*lim + 1);
		return fix16_t'(int'(r) - lim);
	endfunction

	function automatic cmd_word_u conv_word(input int taps, input fix16_t bias);
		cmd_word_u c;
		c             = '0;
		c.conv.opcode = OP_CONV;
		c.conv.taps   = 8'(taps);
		c.conv.bias   = bias;
		return c;
	endfunction

	function automatic cmd_word_u pool_word(input opcode_e op, input int windows);
		cmd_word_u c;
		c              = '0;
		c.pool.opcode  = op;
		c.pool.windows = 8'(windows);
		return c;
	endfunction

	task automatic check_level(input string what, input logic want, input logic act);
		if (act !== want) begin
			errors++;
			$display("MISMATCH reset: %s expected %0b actual %0b", what, want, act);
		end
	endtask

	// All tasks below start and end one drive delay after a rising edge
	task automatic send_cmd(input cmd_word_u c);
		cmd    = c;
		cmd_wr = 1'b1;
		@(posedge okClk);
		#DRIVE_DLY;
		cmd_wr = 1'b0;
	endtask

	task automatic drive_beat(input fix16_t s, input lane_vec_t w);
		while (!in_ready) begin
			@(posedge okClk);
			#DRIVE_DLY;
		end
		in_valid      = 1'b1;
		in_op.sample  = s;
		in_op.weights = w;
		@(posedge okClk);                  // Accepted on this edge
		#DRIVE_DLY;
		in_valid = 1'b0;
	endtask

	task automatic stream_cmd(input string name, input cmd_word_u c, input bit force_sat);
		fix16_t    smp[$];
		lane_vec_t wts[$];
		lane_vec_t w;
		result_t   want;
		int        beats;
		int        i;
		int        l;
		case (c.conv.opcode)
			OP_CONV:    beats = int'(c.conv.taps);
			OP_MAXPOOL: beats = int'(c.pool.windows) * MAXPOOL_WIN;
			default:    beats = int'(c.pool.windows) * AVEPOOL_WIN;
		endcase
		for (i = 0; i < beats; i++) begin
			for (l = 0; l < PARA; l++) begin
				if (!force_sat)
					w[l] = rand_fix(WT_LIM);
				else if (l < PARA/2)
					w[l] = 16'sh7F00;      // +127.0 pushes these lanes high
				else
					w[l] = 16'sh8100;      // -127.0 pushes these lanes low
			end
			if (force_sat)
				smp.push_back(16'sh7F00);
			else if (c.conv.opcode == OP_CONV)
				smp.push_back(rand_fix(CONV_LIM));
			else
				smp.push_back(rand_fix(POOL_LIM));
			wts.push_back(w);
		end
		if (c.conv.opcode == OP_CONV) begin
			want      = '0;
			want.kind = OP_CONV;
			for (l = 0; l < PARA; l++)
				want.value[l] = ref_conv(smp, wts, l, c.conv.bias);
			exp_q.push_back(want);
			name_q.push_back(name);
		end else begin
			for (i = 0; i < int'(c.pool.windows); i++) begin
				want      = '0;
				want.kind = c.pool.opcode;
				if (c.pool.opcode == OP_MAXPOOL)
					want.value[0] = ref_maxpool(smp, i*MAXPOOL_WIN);
				else
					want.value[0] = ref_avepool(smp, i*AVEPOOL_WIN);
				exp_q.push_back(want);
				name_q.push_back(name);
			end
		end
		for (i = 0; i < beats; i++)
			drive_beat(smp[i], wts[i]);
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(posedge okClk);
			#DRIVE_DLY;
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected results never arrived", exp_q.size());
			exp_q.delete();
			name_q.delete();
		end
	endtask

	//------------------------------
	// Compare and monitors
	//------------------------------
	always @(negedge okClk) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Result %h arrived with none expected", out_res);
			end else begin
				got_exp  = exp_q.pop_front();
				got_name = name_q.pop_front();
				checked++;
				if (out_res !== got_exp) begin
					errors++;
					$display("MISMATCH %s: expected %h actual %h", got_name, got_exp, out_res);
				end
			end
		end
	end

	always @(negedge okClk) begin
		if (!rst && cmd_err)
			err_pulses++;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	//------------------------------
	// Stimulus
	//------------------------------
	initial begin : stimulus
		cmd_word_u c;
		cmd_word_u burst[$];
		int        i;

		void'($urandom(SEED));
		rst      = 1'b1;
		cmd_wr   = 1'b0;
		cmd      = '0;
		in_valid = 1'b0;
		in_op    = '0;
		repeat (4) @(posedge okClk);
		#DRIVE_DLY;
		rst = 1'b0;

		check_level("in_ready", 1'b0, in_ready);
		check_level("out_valid", 1'b0, out_valid);
		check_level("cmd_err", 1'b0, cmd_err);
		check_level("cmd_full", 1'b0, cmd_full);

		for (i = 0; i < 4; i++) begin
			c = conv_word(1 + int'($urandom % 32), rand_fix(BIAS_LIM));
			send_cmd(c);
			stream_cmd("conv_random", c, 1'b0);
		end
		c = conv_word(4, rand_fix(BIAS_LIM));
		send_cmd(c);
		stream_cmd("conv_saturate", c, 1'b1);   // Lanes 0-1 clip high, 2-3 clip low

		c = pool_word(OP_MAXPOOL, 6);
		send_cmd(c);
		stream_cmd("maxpool", c, 1'b0);

		c = pool_word(OP_AVEPOOL, 2);            // Second window follows with no gap
		send_cmd(c);
		stream_cmd("avepool", c, 1'b0);
		wait_results();

		// Fill the queue while the first command waits for operands
		while (!cmd_full && burst.size() < 2*CMD_DEPTH) begin
			if ($urandom % 2 == 0)
				c = conv_word(1 + int'($urandom % 8), rand_fix(BIAS_LIM));
			else
				c = pool_word(OP_MAXPOOL, 1 + int'($urandom % 2));
			send_cmd(c);
			burst.push_back(c);
		end
		if (!cmd_full) begin
			errors++;
			$display("cmd_full never rose during a burst of %0d commands", burst.size());
		end
		send_cmd(conv_word(1, '0));
		if (!cmd_full) begin
			errors++;
			$display("cmd_full dropped after a write into the full queue");
		end
		for (i = 0; i < burst.size(); i++)
			stream_cmd("burst", burst[i], 1'b0);
		wait_results();
		repeat (4) @(posedge okClk);
		#DRIVE_DLY;
		if (in_ready) begin
			errors++;
			$display("A write refused by cmd_full was queued and started");
		end

		send_cmd(pool_word(OP_RSVD, 1));
		err_pulses_exp++;
		c = conv_word(5, rand_fix(BIAS_LIM));
		send_cmd(c);
		stream_cmd("after_rsvd", c, 1'b0);
		wait_results();
		repeat (4) @(posedge okClk);

		if (err_pulses != err_pulses_exp) begin
			errors++;
			$display("MISMATCH rsvd: cmd_err pulses expected %0d actual %0d",
				err_pulses_exp, err_pulses);
		end
		$display("Done: %0d results checked, %0d errors", checked, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
